// File: run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator, run it, decide pass or fail from the log
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module wb_sys_tb -f wb_sys_top.f -o wb_sys_tb_sim \
	|| { echo "Build failed"; exit 1; }
./obj_dir/wb_sys_tb_sim > sim.log 2>&1
cat sim.log
grep -qx "Done: no errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: src/wb_gpio_regs.sv
// GPIO register block, four words; gpio_i is asynchronous and seen two cycles after a change
`timescale 1ns/10ps
`include "wb_sys_settings.svh"

module wb_gpio_regs (
	input  logic                  clk,
	input  logic                  rstn,
	input  wb_sys_pkg::wb_req_t   req_i,
	output wb_sys_pkg::wb_rsp_t   rsp_o,
	input  logic [`WB_DATA_W-1:0] gpio_i,
	output logic [`WB_DATA_W-1:0] gpio_o
);

	import wb_sys_pkg::*;

	localparam int OFF_W = $clog2(`WB_SEL_W);

	// Word offsets inside the window
	localparam logic [1:0] REG_OUT     = 2'd0;
	localparam logic [1:0] REG_IN      = 2'd1;
	localparam logic [1:0] REG_SCRATCH = 2'd2;

	logic [`WB_DATA_W-1:0] gpio_q;
	logic [`WB_DATA_W-1:0] scratch_q;
	logic [`WB_DATA_W-1:0] in_meta_q;
	logic [`WB_DATA_W-1:0] in_sync_q;
	logic [`WB_DATA_W-1:0] rd_word;
	logic [`WB_DATA_W-1:0] dat_q;
	logic [1:0]            reg_off;
	logic                  start;
	logic                  ack_q;
	logic                  err_q;

	assign reg_off = req_i.adr[OFF_W +: 2];
	// New access only when no response is pending
	assign start   = req_i.cyc && req_i.stb && !ack_q && !err_q;

	// Two-flop input synchronizer
	always_ff @(posedge clk) begin
		if (!rstn) begin
			in_meta_q <= '0;
			in_sync_q <= '0;
		end else begin
			in_meta_q <= gpio_i;
			in_sync_q <= in_meta_q;
		end
	end

	// Register writes and response pulses
	always_ff @(posedge clk) begin
		if (!rstn) begin
			gpio_q    <= '0;
			scratch_q <= '0;
			ack_q     <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			ack_q <= start && (reg_off != 2'd3);
			// Offset 3 is unmapped
			err_q <= start && (reg_off == 2'd3);
			if (start && req_i.we && reg_off == REG_OUT) begin
				gpio_q <= merge_bytes(gpio_q, req_i.dat_w, req_i.sel);
			end
			if (start && req_i.we && reg_off == REG_SCRATCH) begin
				scratch_q <= merge_bytes(scratch_q, req_i.dat_w, req_i.sel);
			end
		end
	end

	// Read select, writes to the input word fall through here and are ignored
	always_comb begin
		case (reg_off)
			REG_OUT:     rd_word = gpio_q;
			REG_IN:      rd_word = in_sync_q;
			REG_SCRATCH: rd_word = scratch_q;
			default:     rd_word = '0;
		endcase
	end

	// Read data held for the response cycle
	always_ff @(posedge clk) begin
		if (start) begin
			dat_q <= rd_word;
		end
	end

	assign rsp_o  = '{dat_r: dat_q, ack: ack_q, err: err_q};
	assign gpio_o = gpio_q;

endmodule

// File: src/wb_interconnect_1x3.sv
// One master to three targets; target is latched for the whole cycle, unmapped addresses get err
`timescale 1ns/10ps
`include "wb_sys_settings.svh"

module wb_interconnect_1x3 (
	input  logic                clk,
	input  logic                rstn,
	// Master side
	input  wb_sys_pkg::wb_req_t m_req_i,
	output wb_sys_pkg::wb_rsp_t m_rsp_o,
	// Target 0, SRAM0 window
	output wb_sys_pkg::wb_req_t s0_req_o,
	input  wb_sys_pkg::wb_rsp_t s0_rsp_i,
	// Target 1, SRAM1 window
	output wb_sys_pkg::wb_req_t s1_req_o,
	input  wb_sys_pkg::wb_rsp_t s1_rsp_i,
	// Target 2, GPIO window
	output wb_sys_pkg::wb_req_t s2_req_o,
	input  wb_sys_pkg::wb_rsp_t s2_rsp_i
);

	import wb_sys_pkg::*;

	// Window match in fixed order, first hit wins
	function automatic wb_tgt_e decode_adr(input logic [`WB_ADDR_W-1:0] adr);
		wb_tgt_e tgt;
		tgt = TGT_ERR;
		if (adr >= `SRAM0_BASE && adr <= `SRAM0_LIMIT) begin
			tgt = TGT_SRAM0;
		end else if (adr >= `SRAM1_BASE && adr <= `SRAM1_LIMIT) begin
			tgt = TGT_SRAM1;
		end else if (adr >= `GPIO_BASE && adr <= `GPIO_LIMIT) begin
			tgt = TGT_GPIO;
		end
		return tgt;
	endfunction

	// Idle/busy flag and the target held for the current cycle
	logic    busy_q;
	wb_tgt_e tgt_q;
	wb_tgt_e adr_tgt;

	// Decode-fail responder port
	wb_req_t err_req;
	wb_rsp_t err_rsp;
	logic    err_q;

	// Response of the latched target
	wb_rsp_t sel_rsp;

	// Decode straight from the master address
	always_comb begin
		adr_tgt = decode_adr(m_req_i.adr);
	end

	// Latch on request start, release on ack or err
	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_q <= 1'b0;
			tgt_q  <= TGT_ERR;
		end else if (!busy_q) begin
			if (m_req_i.cyc && m_req_i.stb) begin
				busy_q <= 1'b1;
				tgt_q  <= adr_tgt;
			end
		end else if (sel_rsp.ack || sel_rsp.err) begin
			busy_q <= 1'b0;
		end else if (!m_req_i.cyc) begin
			// Master abandoned the cycle
			busy_q <= 1'b0;
		end
	end

	// Request fan-out, unselected targets see all zero
	always_comb begin
		s0_req_o = '0;
		s1_req_o = '0;
		s2_req_o = '0;
		err_req  = '0;
		if (busy_q) begin
			case (tgt_q)
				TGT_SRAM0: s0_req_o = m_req_i;
				TGT_SRAM1: s1_req_o = m_req_i;
				TGT_GPIO:  s2_req_o = m_req_i;
				default:   err_req  = m_req_i;
			endcase
		end
	end

	// Decode-fail responder
	// err one cycle after stb, single pulse
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= err_req.cyc && err_req.stb && !err_q;
		end
	end

	// No data and never an ack from the fail path
	always_comb begin
		err_rsp       = '0;
		err_rsp.err   = err_q;
	end

	// Response mux, zero while idle
	always_comb begin
		sel_rsp = '0;
		if (busy_q) begin
			case (tgt_q)
				TGT_SRAM0: sel_rsp = s0_rsp_i;
				TGT_SRAM1: sel_rsp = s1_rsp_i;
				TGT_GPIO:  sel_rsp = s2_rsp_i;
				default:   sel_rsp = err_rsp;
			endcase
		end
	end

	assign m_rsp_o = sel_rsp;

endmodule

// File: src/wb_sram.sv
// Word SRAM target; WORDS must be a power of two of at least 2, word index wraps modulo WORDS
`timescale 1ns/10ps
`include "wb_sys_settings.svh"

module wb_sram #(
	parameter int WORDS = `SRAM_WORDS,
	parameter int WAIT  = `SRAM_WAIT
) (
	input  logic                clk,
	input  logic                rstn,
	input  wb_sys_pkg::wb_req_t req_i,
	output wb_sys_pkg::wb_rsp_t rsp_o
);

	import wb_sys_pkg::*;

	// Byte offset bits below the word index
	localparam int OFF_W = $clog2(`WB_SEL_W);
	localparam int IDX_W = $clog2(WORDS);
	// Wait counter needs at least one bit
	localparam int CNT_W = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

	logic [`WB_DATA_W-1:0] mem [WORDS];

	logic [CNT_W-1:0]      cnt_q;
	logic                  ack_q;
	logic [`WB_DATA_W-1:0] dat_q;
	logic [IDX_W-1:0]      idx;
	logic                  access;
	logic                  done;

	// Word index, upper address bits dropped
	assign idx    = req_i.adr[OFF_W +: IDX_W];
	assign access = req_i.cyc && req_i.stb;
	// Last wait cycle, guarded against a second ack while stb lingers
	assign done   = access && !ack_q && (cnt_q == CNT_W'(WAIT));

	// Wait counter and ack pulse
	always_ff @(posedge clk) begin
		if (!rstn) begin
			cnt_q <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= done;
			if (access && !ack_q && !done) begin
				cnt_q <= cnt_q + CNT_W'(1);
			end else begin
				cnt_q <= '0;
			end
		end
	end

	// Storage, only selected byte lanes written
	always_ff @(posedge clk) begin
		if (done && req_i.we) begin
			mem[idx] <= merge_bytes(mem[idx], req_i.dat_w, req_i.sel);
		end
	end

	// Read word lands together with ack
	always_ff @(posedge clk) begin
		if (done) begin
			dat_q <= mem[idx];
		end
	end

	assign rsp_o = '{dat_r: dat_q, ack: ack_q, err: 1'b0};

endmodule

// File: src/wb_sys_pkg.sv
// Shared Wishbone classic types; no CTI/BTE fields, so only single classic cycles are described
`include "wb_sys_settings.svh"

package wb_sys_pkg;

	// Master to target request, field order fixes the packed layout
	typedef struct packed {
		logic [`WB_ADDR_W-1:0] adr;
		logic [`WB_DATA_W-1:0] dat_w;
		logic [`WB_SEL_W-1:0]  sel;
		logic                  we;
		logic                  cyc;
		logic                  stb;
	} wb_req_t;

	// Target to master response
	typedef struct packed {
		logic [`WB_DATA_W-1:0] dat_r;
		logic                  ack;
		logic                  err;
	} wb_rsp_t;

	// Decoded target, TGT_ERR is the decode-fail responder
	typedef enum logic [1:0] {
		TGT_SRAM0 = 2'd0,
		TGT_SRAM1 = 2'd1,
		TGT_GPIO  = 2'd2,
		TGT_ERR   = 2'd3
	} wb_tgt_e;

	// Byte-select write merge shared by every writable target
	function automatic logic [`WB_DATA_W-1:0] merge_bytes(
		input logic [`WB_DATA_W-1:0] old_w,
		input logic [`WB_DATA_W-1:0] new_w,
		input logic [`WB_SEL_W-1:0]  sel
	);
		logic [`WB_DATA_W-1:0] res;
		res = old_w;
		for (int b = 0; b < `WB_SEL_W; b++) begin
			// Lane b carries bits 8*b up to 8*b+7
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

endpackage

// File: src/wb_sys_settings.svh
// Bus widths and address map; windows are inclusive and must not overlap
`ifndef WB_SYS_SETTINGS_SVH
`define WB_SYS_SETTINGS_SVH

// Byte address, data word and byte-select widths
`define WB_ADDR_W 32
`define WB_DATA_W 32
`define WB_SEL_W 4

// Target 0 is the first SRAM of 1 KiB
`define SRAM0_BASE 32'h0000_0000
`define SRAM0_LIMIT 32'h0000_03FF

// Target 1 is the second SRAM of 1 KiB
`define SRAM1_BASE 32'h0001_0000
`define SRAM1_LIMIT 32'h0001_03FF

// Target 2 is the GPIO register block of four words
`define GPIO_BASE 32'h0002_0000
`define GPIO_LIMIT 32'h0002_000F

// SRAM geometry and access latency
`define SRAM_WORDS 256
`define SRAM_WAIT 1

`endif

// File: src/wb_sys_top.sv
// One Wishbone classic master only; memory map and SRAM latency come from the macro header
`timescale 1ns/10ps
`include "wb_sys_settings.svh"

module wb_sys_top (
	input  logic                  clk,
	input  logic                  rstn,
	// Master port
	input  wb_sys_pkg::wb_req_t   m_req_i,
	output wb_sys_pkg::wb_rsp_t   m_rsp_o,
	// GPIO pins
	input  logic [`WB_DATA_W-1:0] gpio_i,
	output logic [`WB_DATA_W-1:0] gpio_o
);

	import wb_sys_pkg::*;

	// Interconnect to target links
	wb_req_t s0_req;
	wb_rsp_t s0_rsp;
	wb_req_t s1_req;
	wb_rsp_t s1_rsp;
	wb_req_t s2_req;
	wb_rsp_t s2_rsp;

	// Address decode and routing
	wb_interconnect_1x3 ic_inst (
		.clk      (clk),
		.rstn     (rstn),
		.m_req_i  (m_req_i),
		.m_rsp_o  (m_rsp_o),
		.s0_req_o (s0_req),
		.s0_rsp_i (s0_rsp),
		.s1_req_o (s1_req),
		.s1_rsp_i (s1_rsp),
		.s2_req_o (s2_req),
		.s2_rsp_i (s2_rsp)
	);

	// Target 0
	wb_sram #(
		.WORDS (`SRAM_WORDS),
		.WAIT  (`SRAM_WAIT)
	) sram0_inst (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (s0_req),
		.rsp_o (s0_rsp)
	);

	// Target 1 with the same geometry
	wb_sram #(
		.WORDS (`SRAM_WORDS),
		.WAIT  (`SRAM_WAIT)
	) sram1_inst (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (s1_req),
		.rsp_o (s1_rsp)
	);

	// Target 2 is the register block
	wb_gpio_regs gpio_inst (
		.clk    (clk),
		.rstn   (rstn),
		.req_i  (s2_req),
		.rsp_o  (s2_rsp),
		.gpio_i (gpio_i),
		.gpio_o (gpio_o)
	);

endmodule

// File: verif/wb_sys_tb.sv
// Single master only; both SRAMs are filled first because their contents are not reset
`timescale 1ns/10ps
`include "wb_sys_settings.svh"

module wb_sys_tb;

	import wb_sys_pkg::*;

	localparam int TXN_COUNT = 2000;
	localparam int TIMEOUT   = 20;
	localparam int DRIVE_DLY = 2;
	localparam int IDX_W     = $clog2(`SRAM_WORDS);

	logic                  clk;
	logic                  rstn;
	wb_req_t               m_req;
	wb_rsp_t               m_rsp;
	logic [`WB_DATA_W-1:0] gpio_in;
	logic [`WB_DATA_W-1:0] gpio_out;
	integer                seed;

	// Reference model state
	logic [`WB_DATA_W-1:0] sram0_model [`SRAM_WORDS];
	logic [`WB_DATA_W-1:0] sram1_model [`SRAM_WORDS];
	logic [`WB_DATA_W-1:0] gpio_model;
	logic [`WB_DATA_W-1:0] scratch_model;

	wb_sys_top wb_sys_top_inst (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp),
		.gpio_i  (gpio_in),
		.gpio_o  (gpio_out)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Prints the reason, then the fail message, then stops
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act);
		string exp_s;
		string act_s;
		if (act !== exp) begin
			exp_s = $sformatf("dat_r=%h ack=%b err=%b", exp.dat_r, exp.ack, exp.err);
			act_s = $sformatf("dat_r=%h ack=%b err=%b", act.dat_r, act.ack, act.err);
			abort_run($sformatf("CHECK FAILED %s: expected %s, actual %s",
				name, exp_s, act_s));
		end
	endtask

	task automatic check_gpio(input string name, input logic [`WB_DATA_W-1:0] exp,
		input logic [`WB_DATA_W-1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("CHECK FAILED %s: expected gpio_o=%h, actual gpio_o=%h",
				name, exp, act));
		end
	endtask

	// Inclusive windows checked in map order
	function automatic wb_tgt_e target_of(input logic [`WB_ADDR_W-1:0] adr);
		if (adr >= `SRAM0_BASE && adr <= `SRAM0_LIMIT)
			return TGT_SRAM0;
		if (adr >= `SRAM1_BASE && adr <= `SRAM1_LIMIT)
			return TGT_SRAM1;
		if (adr >= `GPIO_BASE && adr <= `GPIO_LIMIT)
			return TGT_GPIO;
		return TGT_ERR;
	endfunction

	// Selected byte lanes take the new data
	function automatic logic [`WB_DATA_W-1:0] lane_write(input logic [`WB_DATA_W-1:0] old_w,
		input logic [`WB_DATA_W-1:0] new_w, input logic [`WB_SEL_W-1:0] sel);
		logic [`WB_DATA_W-1:0] mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	// Initial SRAM word that depends on every address bit
	function automatic logic [`WB_DATA_W-1:0] fill_word(input logic [`WB_ADDR_W-1:0] adr);
		return adr ^ {adr[15:0], adr[31:16]} ^ 32'hC3A5_5A3C;
	endfunction

	// One classic cycle held until ack or err and followed by one idle cycle
	task automatic bus_xfer(input string name, input wb_req_t req, output wb_rsp_t rsp);
		int   cycles;
		logic got;
		m_req  = req;
		cycles = 0;
		got    = 1'b0;
		rsp    = '0;
		while (!got && cycles < TIMEOUT) begin
			@(posedge clk);
			#DRIVE_DLY;
			cycles++;
			if (m_rsp.ack || m_rsp.err) begin
				got = 1'b1;
				rsp = m_rsp;
			end
		end
		if (!got) begin
			abort_run($sformatf("%s: no ack or err within %0d cycles", name, TIMEOUT));
		end
		if (rsp.ack && rsp.err) begin
			abort_run($sformatf("%s: ack and err were raised together", name));
		end
		// Request still held through the edge that ends the cycle
		@(posedge clk);
		#DRIVE_DLY;
		m_req = '0;
		// Interconnect is idle again and the response must be zero
		check_rsp({name, " after end"}, '0, m_rsp);
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// Model update and expected response before the bus cycle and its checks
	task automatic run_txn(input logic [`WB_ADDR_W-1:0] adr, input logic we,
		input logic [`WB_SEL_W-1:0] sel, input logic [`WB_DATA_W-1:0] dat, input string name);
		wb_req_t          req;
		wb_rsp_t          rsp;
		wb_rsp_t          exp;
		logic [IDX_W-1:0] idx;
		req = '{adr: adr, dat_w: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
		exp = '0;
		exp.ack = 1'b1;
		case (target_of(adr))
			TGT_SRAM0: begin
				idx = IDX_W'((adr - `SRAM0_BASE) >> 2);
				if (we)
					sram0_model[idx] = lane_write(sram0_model[idx], dat, sel);
				else
					exp.dat_r = sram0_model[idx];
			end
			TGT_SRAM1: begin
				idx = IDX_W'((adr - `SRAM1_BASE) >> 2);
				if (we)
					sram1_model[idx] = lane_write(sram1_model[idx], dat, sel);
				else
					exp.dat_r = sram1_model[idx];
			end
			TGT_GPIO: begin
				// Word offset inside the register window
				case (adr[3:2])
					2'd0: begin
						if (we)
							gpio_model = lane_write(gpio_model, dat, sel);
						else
							exp.dat_r = gpio_model;
					end
					2'd1: begin
						// Read-only word where writes are acked and dropped
						if (!we)
							exp.dat_r = gpio_in;
					end
					2'd2: begin
						if (we)
							scratch_model = lane_write(scratch_model, dat, sel);
						else
							exp.dat_r = scratch_model;
					end
					default: begin
						exp.ack = 1'b0;
						exp.err = 1'b1;
					end
				endcase
			end
			default: begin
				exp.ack = 1'b0;
				exp.err = 1'b1;
			end
		endcase
		bus_xfer(name, req, rsp);
		// Read data is undefined on a write
		if (we)
			rsp.dat_r = '0;
		check_rsp(name, exp, rsp);
		check_gpio(name, gpio_model, gpio_out);
	endtask

	// New gpio_i value held past the synchronizer
	task automatic drive_gpio_input(input logic [`WB_DATA_W-1:0] val);
		gpio_in = val;
		repeat (3) @(posedge clk);
		#DRIVE_DLY;
	endtask

	// Random target, direction, byte selects and data
	task automatic random_txn(input int n);
		logic [31:0]           r_adr;
		logic [31:0]           r_ctl;
		logic [`WB_DATA_W-1:0] r_dat;
		logic [`WB_ADDR_W-1:0] adr;
		r_adr = $random(seed);
		r_dat = $random(seed);
		r_ctl = $random(seed);
		case (r_ctl[1:0])
			2'd0: adr = `SRAM0_BASE + (r_adr % (`SRAM0_LIMIT - `SRAM0_BASE + 1));
			2'd1: adr = `SRAM1_BASE + (r_adr % (`SRAM1_LIMIT - `SRAM1_BASE + 1));
			2'd2: adr = `GPIO_BASE + (r_adr % (`GPIO_LIMIT - `GPIO_BASE + 1));
			default: begin
				// Far away or just past one of the limits
				if (r_ctl[5])
					adr = {1'b1, r_adr[30:0]};
				else if (r_ctl[7:6] == 2'd0)
					adr = `SRAM0_LIMIT + 1 + r_adr[7:0];
				else if (r_ctl[7:6] == 2'd1)
					adr = `SRAM1_LIMIT + 1 + r_adr[7:0];
				else
					adr = `GPIO_LIMIT + 1 + r_adr[7:0];
			end
		endcase
		run_txn(adr, r_ctl[12], r_ctl[11:8], r_dat,
			$sformatf("txn %0d %s adr %h", n, r_ctl[12] ? "write" : "read", adr));
	endtask

	initial begin
		m_req         = '0;
		gpio_in       = '0;
		rstn          = 1'b0;
		seed          = 32'h48497730;
		gpio_model    = '0;
		scratch_model = '0;
		repeat (8) @(posedge clk);
		#DRIVE_DLY;
		rstn = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		check_gpio("reset gpio_o", '0, gpio_out);
		run_txn(`GPIO_BASE + 32'h8, 1'b0, 4'hF, '0, "reset scratch read");
		// Full-word writes give every SRAM word a known value
		for (int w = 0; w < `SRAM_WORDS; w++) begin
			run_txn(`SRAM0_BASE + 4 * w, 1'b1, 4'hF, fill_word(`SRAM0_BASE + 4 * w),
				"fill sram0");
			run_txn(`SRAM1_BASE + 4 * w, 1'b1, 4'hF, fill_word(`SRAM1_BASE + 4 * w),
				"fill sram1");
		end
		for (int n = 0; n < TXN_COUNT; n++) begin
			// Roughly one in eight transactions sees a new input value first
			if (($random(seed) & 7) == 0)
				drive_gpio_input($random(seed));
			random_txn(n);
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: wb_sys_top.f
+incdir+src
src/wb_sys_pkg.sv
src/wb_interconnect_1x3.sv
src/wb_sram.sv
src/wb_gpio_regs.sv
src/wb_sys_top.sv
verif/wb_sys_tb.sv
